// File: noc_output_switch.f
verilog/noc_switch_pkg.sv
verilog/noc_flit_decoder.sv
verilog/noc_round_robin_arbiter.sv
verilog/noc_vc_mux_fifo.sv
verilog/noc_vc_merger.sv
verilog/noc_output_switch.sv
sim/noc_output_checker.sv
sim/noc_output_switch_tb.sv

// File: sim/noc_output_checker.sv
`default_nettype none
`timescale 1ns/10ps

module noc_output_checker #(
  parameter int CHANNELS = 2
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             out_valid,
  input  logic [(CHANNELS > 1 ? $clog2(CHANNELS) : 1)-1:0] out_vc,
  input  logic [noc_switch_pkg::FLIT_WIDTH-1:0]            out_flit,
  input  logic [CHANNELS-1:0]                              out_ready,
  output int                                               errors,
  output int                                               received,
  output logic                                             done
);
  import noc_switch_pkg::*;

  localparam string TRACE_FILE = "sim/noc_output_trace.txt";
  localparam int MAX_PKTS  = 64;
  localparam int MAX_TESTS = 16;
  localparam int SRC_LSB   = 13;
  localparam int NUM_LSB   = 10;
  localparam int RR_TEST   = 3;

  int   n_pkts;
  int   total_flits;
  int   rr_seen;
  int   pkt_test [MAX_PKTS];
  int   pkt_port [MAX_PKTS];
  int   pkt_vc   [MAX_PKTS];
  int   pkt_len  [MAX_PKTS];
  logic pkt_done [MAX_PKTS];
  int   test_left[MAX_TESTS];
  int   test_err [MAX_TESTS];
  int   cur_pkt  [CHANNELS];
  int   cur_idx  [CHANNELS];

  assign done = (total_flits > 0) && (received >= total_flits);

  // Flit i of the trace packet, built from the payload convention
  function automatic logic [FLIT_WIDTH-1:0] expected_flit(input int i, input int f);
    flit_type_e               ftype;
    logic [PAYLOAD_WIDTH-1:0] payload;

    if (pkt_len[i] == 1) ftype = FLIT_SINGLE;
    else if (f == 0) ftype = FLIT_HEAD;
    else if (f == pkt_len[i] - 1) ftype = FLIT_TAIL;
    else ftype = FLIT_BODY;
    payload = '0;
    payload[PAYLOAD_WIDTH-1:SRC_LSB] = pkt_port[i];
    payload[SRC_LSB-1:NUM_LSB]       = i % 8;
    payload[NUM_LSB-1:0]             = f;
    return {ftype, payload};
  endfunction

  initial begin : load_trace
    int fd, t, p, v, n, s, st;

    errors      = 0;
    received    = 0;
    n_pkts      = 0;
    total_flits = 0;
    rr_seen     = 0;
    for (int k = 0; k < MAX_TESTS; k++) begin
      test_left[k] = 0;
      test_err[k]  = 0;
    end
    for (int c = 0; c < CHANNELS; c++) begin
      cur_pkt[c] = -1;
      cur_idx[c] = 0;
    end
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("Checker could not open trace file %s", TRACE_FILE);
    end else begin
      while ($fscanf(fd, "%d %d %d %d %d %d", t, p, v, n, s, st) == 6) begin
        pkt_test[n_pkts] = t;
        pkt_port[n_pkts] = p;
        pkt_vc[n_pkts]   = v;
        pkt_len[n_pkts]  = n;
        pkt_done[n_pkts] = 1'b0;
        test_left[t]    += n;
        total_flits     += n;
        n_pkts++;
      end
      $fclose(fd);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output link monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sampled mid-cycle, where the values equal those at the next edge
  always @(negedge clk) begin : watch
    int v, p, i, t;
    logic [FLIT_WIDTH-1:0] exp_flit;

    if (rst_n && out_valid) begin
      v = int'(out_vc);
      if (!out_ready[v]) begin
        errors++;
        $display("Error at %0t: out_valid shows channel %0d while its out_ready is low",
                 $time, v);
      end else begin
        received++;
        // A new packet on this channel, found by its source port
        if (cur_pkt[v] < 0) begin
          p = int'(out_flit[PAYLOAD_WIDTH-1:SRC_LSB]);
          i = -1;
          for (int k = n_pkts - 1; k >= 0; k--) begin
            if (!pkt_done[k] && pkt_port[k] == p && pkt_vc[k] == v) i = k;
          end
          if (i < 0) begin
            errors++;
            $display("Error at %0t: flit %h on channel %0d has no packet pending from port %0d",
                     $time, out_flit, v, p);
          end else begin
            cur_pkt[v] = i;
            cur_idx[v] = 0;
            if (pkt_test[i] == RR_TEST) begin
              if (p != rr_seen) begin
                errors++;
                test_err[RR_TEST]++;
                $display("Mismatch at %0t: out_flit header source port expected %0d got %0d",
                         $time, rr_seen, p);
              end
              rr_seen++;
            end
          end
        end
        if (cur_pkt[v] >= 0) begin
          i = cur_pkt[v];
          t = pkt_test[i];
          exp_flit = expected_flit(i, cur_idx[v]);
          if (out_flit !== exp_flit) begin
            errors++;
            test_err[t]++;
            $display("Mismatch at %0t: out_flit on channel %0d expected %h got %h",
                     $time, v, exp_flit, out_flit);
          end
          cur_idx[v]++;
          test_left[t]--;
          if (cur_idx[v] == pkt_len[i]) begin
            pkt_done[i] = 1'b1;
            cur_pkt[v]  = -1;
          end
          if (test_left[t] == 0) begin
            $display("Test %0d finished at %0t with %0d errors", t, $time, test_err[t]);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/noc_output_switch_tb.sv
`default_nettype none
`timescale 1ns/10ps

module noc_output_switch_tb;
  import noc_switch_pkg::*;

  localparam string TRACE_FILE = "sim/noc_output_trace.txt";
  localparam int CHANNELS = 2;
  localparam int VC_W     = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
  localparam int MAX_PKTS = 64;
  localparam int SRC_LSB  = 13;
  localparam int NUM_LSB  = 10;

  logic                                           clk;
  logic                                           rst_n;
  logic [PORTS-1:0][CHANNELS-1:0]                 in_valid;
  logic [PORTS-1:0][CHANNELS-1:0][FLIT_WIDTH-1:0] in_flit;
  logic [PORTS-1:0][CHANNELS-1:0]                 in_ready;
  logic                                           out_valid;
  logic [VC_W-1:0]                                out_vc;
  logic [FLIT_WIDTH-1:0]                          out_flit;
  logic [CHANNELS-1:0]                            out_ready;

  int          n_pkts;
  int          total_flits;
  int          stall_start;
  int          cycle;
  int          limit;
  int          errors;
  int          received;
  logic        done;
  logic        timed_out;
  logic [31:0] rng_state;
  int          pkt_port [MAX_PKTS];
  int          pkt_vc   [MAX_PKTS];
  int          pkt_len  [MAX_PKTS];
  int          pkt_start[MAX_PKTS];

  initial clk = 1'b0;
  always #50 clk = ~clk;

  noc_output_switch uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_vc    (out_vc),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

  noc_output_checker #(
    .CHANNELS (CHANNELS)
  ) u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_vc    (out_vc),
    .out_flit  (out_flit),
    .out_ready (out_ready),
    .errors    (errors),
    .received  (received),
    .done      (done)
  );

  function automatic logic [FLIT_WIDTH-1:0] build_flit(input int i, input int f);
    flit_type_e               ftype;
    logic [PAYLOAD_WIDTH-1:0] payload;

    if (pkt_len[i] == 1) ftype = FLIT_SINGLE;
    else if (f == 0) ftype = FLIT_HEAD;
    else if (f == pkt_len[i] - 1) ftype = FLIT_TAIL;
    else ftype = FLIT_BODY;
    payload = '0;
    payload[PAYLOAD_WIDTH-1:SRC_LSB] = pkt_port[i];
    payload[SRC_LSB-1:NUM_LSB]       = i % 8;
    payload[NUM_LSB-1:0]             = f;
    return {ftype, payload};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clk) begin
    if (!rst_n) cycle <= 0;
    else cycle <= cycle + 1;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Random back-pressure once the first stalled test is due
  always @(posedge clk) begin
    #1;
    if (rst_n && stall_start >= 0 && cycle >= stall_start) begin
      for (int v = 0; v < CHANNELS; v++) begin
        rng_state    = lcg_next(rng_state);
        out_ready[v] = rng_state[31];
      end
    end else begin
      out_ready = '1;
    end
  end

  // Sends the packets of one port and channel in trace order.
  // in_ready is sampled at the falling edge, where it equals its value at the next rise
  task automatic drive_lane(input int p, input int v);
    logic accepted;

    for (int i = 0; i < n_pkts; i++) begin
      if (pkt_port[i] == p && pkt_vc[i] == v) begin
        while (cycle < pkt_start[i]) begin
          @(posedge clk);
          #1;
        end
        for (int f = 0; f < pkt_len[i]; f++) begin
          in_valid[p][v] = 1'b1;
          in_flit[p][v]  = build_flit(i, f);
          accepted = 1'b0;
          while (!accepted) begin
            @(negedge clk);
            accepted = in_ready[p][v];
            @(posedge clk);
            #1;
          end
        end
        in_valid[p][v] = 1'b0;
      end
    end
  endtask

  initial begin : main
    int fd, t, p, v, n, s, st;

    rst_n       = 1'b0;
    in_valid    = '0;
    in_flit     = '0;
    out_ready   = '1;
    cycle       = 0;
    rng_state   = 32'haa284eb4;
    n_pkts      = 0;
    total_flits = 0;
    stall_start = -1;
    timed_out   = 1'b0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Testbench could not open trace file %s", TRACE_FILE);
    end else begin
      while ($fscanf(fd, "%d %d %d %d %d %d", t, p, v, n, s, st) == 6) begin
        pkt_port[n_pkts]  = p;
        pkt_vc[n_pkts]    = v;
        pkt_len[n_pkts]   = n;
        pkt_start[n_pkts] = s;
        total_flits      += n;
        if (st != 0 && (stall_start < 0 || s < stall_start)) stall_start = s;
        n_pkts++;
      end
      $fclose(fd);
    end
    limit = 200 + 8 * total_flits;

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int lp = 0; lp < PORTS; lp++) begin
      for (int lv = 0; lv < CHANNELS; lv++) begin
        fork
          automatic int fp = lp;
          automatic int fv = lv;
          drive_lane(fp, fv);
        join_none
      end
    end

    while (!done && !timed_out) begin
      @(negedge clk);
      if (cycle >= limit) timed_out = 1'b1;
    end
    if (timed_out) begin
      $display("Timeout: run stopped after %0d cycles with %0d of %0d flits received",
               cycle, received, total_flits);
    end
    // A few more cycles so that a duplicated flit would still be counted
    repeat (4) @(negedge clk);
    $display("Summary: %0d packets, %0d of %0d flits received, %0d errors",
             n_pkts, received, total_flits, errors);
    if (!timed_out && errors == 0 && total_flits > 0 && received == total_flits) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/noc_output_trace.txt
1 0 1 1 0 0
1 1 1 1 0 0
1 2 1 1 0 0
1 3 1 1 0 0
1 4 1 1 0 0
2 0 1 4 8 0
2 1 1 3 8 0
2 2 1 5 8 0
2 3 1 2 8 0
2 4 1 4 8 0
3 0 0 3 0 0
3 1 0 3 0 0
3 2 0 3 0 0
3 3 0 3 0 0
3 4 0 3 0 0
4 1 0 2 40 0
4 1 0 3 40 0
4 1 0 1 40 0
4 3 1 3 40 0
4 3 1 2 40 0
5 0 0 4 70 1
5 2 1 3 70 1
5 4 0 1 70 1
5 4 1 5 70 1
5 1 1 2 70 1

// File: verilog/noc_flit_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module noc_flit_decoder (
  input  logic [noc_switch_pkg::PORTS-1:0]                                 in_valid,
  input  logic [noc_switch_pkg::PORTS-1:0][noc_switch_pkg::FLIT_WIDTH-1:0] in_flit,
  input  logic [noc_switch_pkg::PORTS-1:0]                                 in_ready,
  output logic [noc_switch_pkg::PORTS-1:0]                                 request,
  output logic [noc_switch_pkg::PORTS-1:0]                                 free
);
  import noc_switch_pkg::*;

  logic [PORTS-1:0] is_header;
  logic [PORTS-1:0] is_tail;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flit type decode, one per input port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin : decode_type
    flit_type_e ftype;

    for (int p = 0; p < PORTS; p++) begin
      ftype = flit_type_e'(in_flit[p][FLIT_WIDTH-1 -: FLIT_TYPE_WIDTH]);
      is_header[p] = (ftype == FLIT_HEAD) || (ftype == FLIT_SINGLE);
      is_tail[p]   = (ftype == FLIT_TAIL) || (ftype == FLIT_SINGLE);
    end
  end

  // A header only asks for the channel while it is actually offered
  assign request = in_valid & is_header;

  // Release happens on the handshake of the closing flit, not on the offer
  assign free = in_valid & in_ready & is_tail;

endmodule

`default_nettype wire

// File: verilog/noc_output_switch.sv
`default_nettype none
`timescale 1ns/10ps

module noc_output_switch #(
  parameter int CHANNELS   = 2,
  parameter int FIFO_DEPTH = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic [noc_switch_pkg::PORTS-1:0][CHANNELS-1:0]  in_valid,
  input  logic [noc_switch_pkg::PORTS-1:0][CHANNELS-1:0]
               [noc_switch_pkg::FLIT_WIDTH-1:0]            in_flit,
  output logic [noc_switch_pkg::PORTS-1:0][CHANNELS-1:0]  in_ready,
  output logic                                             out_valid,
  output logic [(CHANNELS > 1 ? $clog2(CHANNELS) : 1)-1:0] out_vc,
  output logic [noc_switch_pkg::FLIT_WIDTH-1:0]            out_flit,
  input  logic [CHANNELS-1:0]                              out_ready
);
  import noc_switch_pkg::*;

  logic [CHANNELS-1:0]                 fifo_valid;
  logic [CHANNELS-1:0][FLIT_WIDTH-1:0] fifo_flit;
  logic [CHANNELS-1:0]                 fifo_pop;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Per virtual channel decode, arbitration and buffering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar g = 0; g < CHANNELS; g++) begin : g_channel
    logic [PORTS-1:0]                 vc_valid;
    logic [PORTS-1:0][FLIT_WIDTH-1:0] vc_flit;
    logic [PORTS-1:0]                 vc_ready;
    logic [PORTS-1:0]                 request;
    logic [PORTS-1:0]                 free;
    logic [PORTS-1:0]                 grant;

    // Pull this channel's slice out of the port-major arrays
    for (genvar p = 0; p < PORTS; p++) begin : g_port
      assign vc_valid[p]    = in_valid[p][g];
      assign vc_flit[p]     = in_flit[p][g];
      assign in_ready[p][g] = vc_ready[p];
    end

    noc_flit_decoder u_decoder (
      .in_valid (vc_valid),
      .in_flit  (vc_flit),
      .in_ready (vc_ready),
      .request  (request),
      .free     (free)
    );

    noc_round_robin_arbiter u_arbiter (
      .clk     (clk),
      .rst_n   (rst_n),
      .request (request),
      .free    (free),
      .grant   (grant)
    );

    noc_vc_mux_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_mux_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .grant      (grant),
      .in_valid   (vc_valid),
      .in_flit    (vc_flit),
      .in_ready   (vc_ready),
      .fifo_valid (fifo_valid[g]),
      .fifo_flit  (fifo_flit[g]),
      .fifo_pop   (fifo_pop[g])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Shared output link
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  noc_vc_merger #(
    .CHANNELS (CHANNELS)
  ) u_merger (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_valid (fifo_valid),
    .fifo_flit  (fifo_flit),
    .fifo_pop   (fifo_pop),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_vc     (out_vc),
    .out_flit   (out_flit)
  );

endmodule

`default_nettype wire

// File: verilog/noc_round_robin_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

module noc_round_robin_arbiter (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [noc_switch_pkg::PORTS-1:0] request,
  input  logic [noc_switch_pkg::PORTS-1:0] free,
  output logic [noc_switch_pkg::PORTS-1:0] grant
);
  import noc_switch_pkg::*;

  arb_state_e state;
  port_e      last_winner;
  port_e      pick;
  logic       pick_valid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Rotating priority search
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // The port right after the last winner is looked at first
  always_comb begin : rr_search
    int idx;

    pick_valid = 1'b0;
    pick       = last_winner;
    for (int k = 1; k <= PORTS; k++) begin
      idx = (int'(last_winner) + k) % PORTS;
      if (!pick_valid && request[idx]) begin
        pick_valid = 1'b1;
        pick       = port_e'(idx);
      end
    end
  end

  // While locked the grant points at the stored winner
  always_comb begin
    grant = '0;
    if (state == ARB_LOCKED) begin
      grant[last_winner] = 1'b1;
    end else if (pick_valid) begin
      grant[pick] = 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lock control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= ARB_IDLE;
      last_winner <= PORT_LOCAL;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (pick_valid) begin
            last_winner <= pick;
            // A single flit that got through leaves the channel open
            if (!free[pick]) begin
              state <= ARB_LOCKED;
            end
          end
        end
        ARB_LOCKED: begin
          if (free[last_winner]) begin
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/noc_switch_pkg.sv
`default_nettype none

package noc_switch_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Router geometry and flit format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Input ports feeding one output port of the mesh router
  localparam int PORTS = 5;

  localparam int PAYLOAD_WIDTH   = 16;
  localparam int FLIT_TYPE_WIDTH = 2;

  // Flit type sits in the two most significant bits, payload below it
  localparam int FLIT_WIDTH = FLIT_TYPE_WIDTH + PAYLOAD_WIDTH;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A single-flit packet is its own header and tail
  typedef enum logic [FLIT_TYPE_WIDTH-1:0] {
    FLIT_HEAD   = 2'd0,
    FLIT_BODY   = 2'd1,
    FLIT_TAIL   = 2'd2,
    FLIT_SINGLE = 2'd3
  } flit_type_e;

  typedef enum logic [2:0] {
    PORT_X_PLUS  = 3'd0,
    PORT_X_MINUS = 3'd1,
    PORT_Y_PLUS  = 3'd2,
    PORT_Y_MINUS = 3'd3,
    PORT_LOCAL   = 3'd4
  } port_e;

  typedef enum logic {
    ARB_IDLE   = 1'b0,
    ARB_LOCKED = 1'b1
  } arb_state_e;

endpackage

`default_nettype wire

// File: verilog/noc_vc_merger.sv
`default_nettype none
`timescale 1ns/10ps

module noc_vc_merger #(
  parameter int CHANNELS = 2
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic [CHANNELS-1:0]                                  fifo_valid,
  input  logic [CHANNELS-1:0][noc_switch_pkg::FLIT_WIDTH-1:0]  fifo_flit,
  output logic [CHANNELS-1:0]                                  fifo_pop,
  input  logic [CHANNELS-1:0]                                  out_ready,
  output logic                                                 out_valid,
  output logic [(CHANNELS > 1 ? $clog2(CHANNELS) : 1)-1:0]     out_vc,
  output logic [noc_switch_pkg::FLIT_WIDTH-1:0]                out_flit
);
  import noc_switch_pkg::*;

  localparam int VC_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

  logic [CHANNELS-1:0] eligible;
  logic [VC_W-1:0]     last_vc;
  logic [VC_W-1:0]     pick_vc;
  logic                pick_valid;

  // Only channels with data and room downstream take part
  assign eligible = fifo_valid & out_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Channel selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin : vc_search
    int idx;

    pick_valid = 1'b0;
    pick_vc    = last_vc;
    for (int k = 1; k <= CHANNELS; k++) begin
      idx = (int'(last_vc) + k) % CHANNELS;
      if (!pick_valid && eligible[idx]) begin
        pick_valid = 1'b1;
        pick_vc    = VC_W'(idx);
      end
    end
  end

  assign out_valid = pick_valid;
  assign out_vc    = pick_vc;
  assign out_flit  = fifo_flit[pick_vc];

  // The chosen channel already has ready high, so a valid cycle is a transfer
  always_comb begin
    fifo_pop = '0;
    if (pick_valid) begin
      fifo_pop[pick_vc] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_vc <= VC_W'(CHANNELS - 1);
    end else if (pick_valid) begin
      last_vc <= pick_vc;
    end
  end

endmodule

`default_nettype wire

// File: verilog/noc_vc_mux_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module noc_vc_mux_fifo #(
  parameter int FIFO_DEPTH = 2
) (
  input  logic                                                             clk,
  input  logic                                                             rst_n,
  input  logic [noc_switch_pkg::PORTS-1:0]                                 grant,
  input  logic [noc_switch_pkg::PORTS-1:0]                                 in_valid,
  input  logic [noc_switch_pkg::PORTS-1:0][noc_switch_pkg::FLIT_WIDTH-1:0] in_flit,
  output logic [noc_switch_pkg::PORTS-1:0]                                 in_ready,
  output logic                                                             fifo_valid,
  output logic [noc_switch_pkg::FLIT_WIDTH-1:0]                            fifo_flit,
  input  logic                                                             fifo_pop
);
  import noc_switch_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [FLIT_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;

  logic                  full;
  logic                  sel_valid;
  logic [FLIT_WIDTH-1:0] sel_flit;
  logic                  push;
  logic                  pop;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Grant is one-hot or zero, so an AND-OR mux is enough
  always_comb begin
    sel_valid = 1'b0;
    sel_flit  = '0;
    for (int p = 0; p < PORTS; p++) begin
      sel_valid = sel_valid | (grant[p] & in_valid[p]);
      sel_flit  = sel_flit | ({FLIT_WIDTH{grant[p]}} & in_flit[p]);
    end
  end

  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign in_ready = grant & {PORTS{~full}};

  assign push = sel_valid & ~full;
  assign pop  = fifo_pop & fifo_valid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Circular buffer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= sel_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head of the queue is presented from the cycle after the write
  assign fifo_valid = (count != '0);
  assign fifo_flit  = mem[rd_ptr];

endmodule

`default_nettype wire
